// ==== common/csr_pkg.sv ====
package csr_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;

    // machine-mode register addresses.
    localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t ADDR_MEPC      = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
    localparam csr_addr_t ADDR_MARCHID   = 12'hF12;

    typedef enum logic [2:0] {
        OP_RW    = 3'd0,  // csrrw.
        OP_RS    = 3'd1,  // csrrs.
        OP_RC    = 3'd2,  // csrrc.
        OP_ECALL = 3'd3,
        OP_MRET  = 3'd4
    } csr_op_e;

    // 79 bits, op in the top bits.
    typedef struct packed {
        csr_op_e   op;
        csr_addr_t addr;
        xlen_t     src;
        xlen_t     pc;
    } csr_req_t;

    localparam xlen_t MVENDORID_RESET = 32'h7973_7978;
    localparam xlen_t MARCHID_RESET   = 32'd22060008;

    localparam xlen_t CAUSE_ECALL_M   = 32'd11;  // environment call from m-mode.

endpackage

// ==== common/csr_if.sv ====
`timescale 1ns/1ps

interface csr_if;

    logic               rena;
    csr_pkg::csr_addr_t raddr;
    csr_pkg::xlen_t     rdata;
    logic               hit;       // address exists.
    logic               writable;  // address not read-only.

    logic               wena;
    csr_pkg::csr_addr_t waddr;
    csr_pkg::xlen_t     wdata;

    logic               trap;
    csr_pkg::xlen_t     trap_pc;

    modport exec (
        output rena, raddr, wena, waddr, wdata, trap, trap_pc,
        input  rdata, hit, writable
    );

    modport regs (
        input  rena, raddr, wena, waddr, wdata, trap, trap_pc,
        output rdata, hit, writable
    );

endinterface

// ==== hw/credit_rx_fifo.sv ====
`timescale 1ns/1ps

module credit_rx_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                push_i,
    input  csr_pkg::csr_req_t   push_data_i,
    input  logic                pop_i,
    output csr_pkg::csr_req_t   pop_data_o,
    output logic                empty_o,
    output logic                credit_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    csr_pkg::csr_req_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clock) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_o <= pop_i;  // one credit back per pop.
        end
    end

    assign pop_data_o = mem[rd_ptr];  // front entry.
    assign empty_o    = (count == '0);

endmodule

// ==== csr/csr_file.sv ====
`timescale 1ns/1ps

module csr_file (
    input  logic clock,
    input  logic reset,
    csr_if.regs  regs
);

    csr_pkg::xlen_t mstatus;
    csr_pkg::xlen_t mtvec;
    csr_pkg::xlen_t mepc;
    csr_pkg::xlen_t mcause;
    csr_pkg::xlen_t mvendorid;
    csr_pkg::xlen_t marchid;

    csr_pkg::xlen_t rd_value;

    always_ff @(posedge clock) begin
        if (reset) begin
            mstatus   <= '0;
            mtvec     <= '0;
            mepc      <= '0;
            mcause    <= '0;
            mvendorid <= csr_pkg::MVENDORID_RESET;
            marchid   <= csr_pkg::MARCHID_RESET;
        end else begin
            if (regs.wena) begin
                case (regs.waddr)
                    csr_pkg::ADDR_MSTATUS: mstatus <= regs.wdata;
                    csr_pkg::ADDR_MTVEC:   mtvec   <= regs.wdata;
                    csr_pkg::ADDR_MEPC:    mepc    <= regs.wdata;
                    csr_pkg::ADDR_MCAUSE:  mcause  <= regs.wdata;
                    default: ;  // read-only or unknown, never enabled.
                endcase
            end
            // ecall entry.
            if (regs.trap) begin
                mepc   <= regs.trap_pc;
                mcause <= csr_pkg::CAUSE_ECALL_M;
            end
        end
    end

    always_comb begin
        rd_value      = '0;
        regs.hit      = 1'b1;
        regs.writable = 1'b1;
        case (regs.raddr)
            csr_pkg::ADDR_MSTATUS: rd_value = mstatus;
            csr_pkg::ADDR_MTVEC:   rd_value = mtvec;
            csr_pkg::ADDR_MEPC:    rd_value = mepc;
            csr_pkg::ADDR_MCAUSE:  rd_value = mcause;
            csr_pkg::ADDR_MVENDORID: begin
                rd_value      = mvendorid;
                regs.writable = 1'b0;
            end
            csr_pkg::ADDR_MARCHID: begin
                rd_value      = marchid;
                regs.writable = 1'b0;
            end
            default: begin
                regs.hit      = 1'b0;  // miss reads zero.
                regs.writable = 1'b0;
            end
        endcase
    end

    assign regs.rdata = regs.rena ? rd_value : '0;

endmodule

// ==== csr/csr_exec.sv ====
`timescale 1ns/1ps

module csr_exec #(
    parameter int RSP_CREDITS = 2
) (
    input  logic               clock,
    input  logic               reset,
    input  csr_pkg::csr_req_t  req_i,
    input  logic               empty_i,
    output logic               pop_o,
    input  logic               rsp_credit_i,
    output logic               rsp_valid_o,
    output csr_pkg::xlen_t     rsp_rdata_o,
    output logic               rsp_illegal_o,
    output logic               rsp_redirect_o,
    output csr_pkg::xlen_t     rsp_target_o,
    csr_if.exec                csr
);

    localparam int CNT_W = $clog2(RSP_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;

    logic           is_rmw;
    logic           is_trap;
    logic           does_write;
    logic           illegal;
    csr_pkg::xlen_t new_val;

    // issue while an entry waits and a response slot is free.
    assign pop_o = !empty_i && (credit_cnt != '0);

    always_comb begin
        is_rmw  = (req_i.op == csr_pkg::OP_RW) || (req_i.op == csr_pkg::OP_RS) ||
                  (req_i.op == csr_pkg::OP_RC);
        is_trap = (req_i.op == csr_pkg::OP_ECALL) || (req_i.op == csr_pkg::OP_MRET);
        case (req_i.op)
            csr_pkg::OP_RW: new_val = req_i.src;
            csr_pkg::OP_RS: new_val = csr.rdata | req_i.src;
            csr_pkg::OP_RC: new_val = csr.rdata & ~req_i.src;
            default:        new_val = csr.rdata;
        endcase
        // set/clear with a zero mask is a pure read.
        does_write = (req_i.op == csr_pkg::OP_RW) || (is_rmw && (req_i.src != '0));
        if (is_rmw) begin
            illegal = !csr.hit || (does_write && !csr.writable);
        end else begin
            illegal = !is_trap;  // undefined op codes.
        end
    end

    always_comb begin
        case (req_i.op)
            csr_pkg::OP_ECALL: csr.raddr = csr_pkg::ADDR_MTVEC;  // trap vector.
            csr_pkg::OP_MRET:  csr.raddr = csr_pkg::ADDR_MEPC;
            default:           csr.raddr = req_i.addr;
        endcase
    end

    assign csr.rena    = pop_o;
    assign csr.wena    = pop_o && is_rmw && does_write && !illegal;
    assign csr.waddr   = req_i.addr;
    assign csr.wdata   = new_val;
    assign csr.trap    = pop_o && (req_i.op == csr_pkg::OP_ECALL);
    assign csr.trap_pc = req_i.pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            credit_cnt  <= CNT_W'(RSP_CREDITS);
            rsp_valid_o <= 1'b0;
        end else begin
            case ({rsp_credit_i, pop_o})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;  // both or neither.
            endcase
            rsp_valid_o <= pop_o;
        end
    end

    always_ff @(posedge clock) begin
        if (pop_o) begin
            rsp_rdata_o    <= (is_rmw && !illegal) ? csr.rdata : '0;
            rsp_illegal_o  <= illegal;
            rsp_redirect_o <= is_trap;
            rsp_target_o   <= is_trap ? csr.rdata : '0;
        end
    end

endmodule

// ==== hw/csr_unit_top.sv ====
`timescale 1ns/1ps

module csr_unit_top #(
    parameter int REQ_DEPTH   = 4,
    parameter int RSP_CREDITS = 2
) (
    input  logic               clock,
    input  logic               reset,

    input  logic               req_valid_i,
    input  logic [2:0]         req_op_i,
    input  csr_pkg::csr_addr_t req_addr_i,
    input  csr_pkg::xlen_t     req_src_i,
    input  csr_pkg::xlen_t     req_pc_i,
    output logic               req_credit_o,

    input  logic               rsp_credit_i,
    output logic               rsp_valid_o,
    output csr_pkg::xlen_t     rsp_rdata_o,
    output logic               rsp_illegal_o,
    output logic               rsp_redirect_o,
    output csr_pkg::xlen_t     rsp_target_o
);

    csr_pkg::csr_req_t req_in;
    csr_pkg::csr_req_t req_head;
    logic              fifo_empty;
    logic              fifo_pop;

    csr_if csr_bus ();

    assign req_in.op   = csr_pkg::csr_op_e'(req_op_i);
    assign req_in.addr = req_addr_i;
    assign req_in.src  = req_src_i;
    assign req_in.pc   = req_pc_i;

    credit_rx_fifo #(
        .DEPTH (REQ_DEPTH)
    ) u_req_fifo (
        .clock       (clock),
        .reset       (reset),
        .push_i      (req_valid_i),
        .push_data_i (req_in),
        .pop_i       (fifo_pop),
        .pop_data_o  (req_head),
        .empty_o     (fifo_empty),
        .credit_o    (req_credit_o)
    );

    csr_exec #(
        .RSP_CREDITS (RSP_CREDITS)
    ) u_exec (
        .clock          (clock),
        .reset          (reset),
        .req_i          (req_head),
        .empty_i        (fifo_empty),
        .pop_o          (fifo_pop),
        .rsp_credit_i   (rsp_credit_i),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_rdata_o    (rsp_rdata_o),
        .rsp_illegal_o  (rsp_illegal_o),
        .rsp_redirect_o (rsp_redirect_o),
        .rsp_target_o   (rsp_target_o),
        .csr            (csr_bus.exec)
    );

    csr_file u_regs (
        .clock (clock),
        .reset (reset),
        .regs  (csr_bus.regs)
    );

endmodule

// ==== testbench/csr_unit_properties.sv ====
`timescale 1ns/1ps

module csr_unit_properties #(
    parameter int RSP_CREDITS = 2
) (
    input logic               clock,
    input logic               reset,
    input logic               req_valid_i,
    input logic [2:0]         req_op_i,
    input csr_pkg::csr_addr_t req_addr_i,
    input csr_pkg::xlen_t     req_src_i,
    input csr_pkg::xlen_t     req_pc_i,
    input logic               req_credit_o,
    input logic               rsp_credit_i,
    input logic               rsp_valid_o,
    input csr_pkg::xlen_t     rsp_rdata_o,
    input logic               rsp_illegal_o,
    input logic               rsp_redirect_o,
    input csr_pkg::xlen_t     rsp_target_o
);

    int error_count = 0;

    csr_pkg::xlen_t sh_mstatus;
    csr_pkg::xlen_t sh_mtvec;
    csr_pkg::xlen_t sh_mepc;
    csr_pkg::xlen_t sh_mcause;

    logic [65:0] exp_mem [256];  // {rdata, illegal, redirect, target}.
    logic [65:0] exp_front;
    logic [7:0]  wr_idx;
    logic [7:0]  rd_idx;

    int rsp_count;
    int rsp_credit_count;
    int accept_count;
    int req_credit_count;

    assign exp_front = exp_mem[rd_idx];

    always @(posedge clock) begin : shadow_model
        csr_pkg::xlen_t old_val;
        csr_pkg::xlen_t new_val;
        logic           hit;
        logic           read_only;
        logic           writes;
        logic           bad;
        if (reset) begin
            sh_mstatus       <= '0;
            sh_mtvec         <= '0;
            sh_mepc          <= '0;
            sh_mcause        <= '0;
            wr_idx           <= '0;
            rd_idx           <= '0;
            rsp_count        <= 0;
            rsp_credit_count <= 0;
            accept_count     <= 0;
            req_credit_count <= 0;
        end else begin
            if (req_valid_i) begin
                hit       = 1'b1;
                read_only = 1'b0;
                case (req_addr_i)
                    csr_pkg::ADDR_MSTATUS:   old_val = sh_mstatus;
                    csr_pkg::ADDR_MTVEC:     old_val = sh_mtvec;
                    csr_pkg::ADDR_MEPC:      old_val = sh_mepc;
                    csr_pkg::ADDR_MCAUSE:    old_val = sh_mcause;
                    csr_pkg::ADDR_MVENDORID: begin
                        old_val   = csr_pkg::MVENDORID_RESET;
                        read_only = 1'b1;
                    end
                    csr_pkg::ADDR_MARCHID: begin
                        old_val   = csr_pkg::MARCHID_RESET;
                        read_only = 1'b1;
                    end
                    default: begin
                        old_val = '0;
                        hit     = 1'b0;
                    end
                endcase
                case (req_op_i)
                    csr_pkg::OP_ECALL: begin
                        exp_mem[wr_idx] <= {32'h0, 1'b0, 1'b1, sh_mtvec};
                        sh_mepc         <= req_pc_i;
                        sh_mcause       <= 32'd11;
                    end
                    csr_pkg::OP_MRET: exp_mem[wr_idx] <= {32'h0, 1'b0, 1'b1, sh_mepc};
                    default: begin
                        if (req_op_i == csr_pkg::OP_RW) begin
                            new_val = req_src_i;
                        end else if (req_op_i == csr_pkg::OP_RS) begin
                            new_val = old_val | req_src_i;
                        end else begin
                            new_val = old_val & ~req_src_i;
                        end
                        writes = (req_op_i == csr_pkg::OP_RW) || (req_src_i != '0);
                        bad    = !hit || (writes && read_only);
                        exp_mem[wr_idx] <= bad ? {32'h0, 1'b1, 1'b0, 32'h0}
                                               : {old_val, 1'b0, 1'b0, 32'h0};
                        if (!bad && writes) begin
                            case (req_addr_i)
                                csr_pkg::ADDR_MSTATUS: sh_mstatus <= new_val;
                                csr_pkg::ADDR_MTVEC:   sh_mtvec   <= new_val;
                                csr_pkg::ADDR_MEPC:    sh_mepc    <= new_val;
                                csr_pkg::ADDR_MCAUSE:  sh_mcause  <= new_val;
                                default: ;
                            endcase
                        end
                    end
                endcase
                wr_idx       <= wr_idx + 8'd1;
                accept_count <= accept_count + 1;
            end
            if (rsp_valid_o) begin
                rd_idx    <= rd_idx + 8'd1;
                rsp_count <= rsp_count + 1;
            end
            rsp_credit_count <= rsp_credit_count + int'(rsp_credit_i);
            req_credit_count <= req_credit_count + int'(req_credit_o);
        end
    end

    assert property (@(posedge clock) reset |=> (!rsp_valid_o && !req_credit_o))
        else begin
            $error("response or credit output active after a reset cycle");
            error_count = error_count + 1;
        end

    assert property (@(posedge clock) disable iff (reset) rsp_valid_o |-> (rd_idx != wr_idx))
        else begin
            $error("response with no request outstanding");
            error_count = error_count + 1;
        end

    assert property (@(posedge clock) disable iff (reset)
            rsp_valid_o |-> (rsp_rdata_o == exp_front[65:34]))
        else begin
            $error("MISMATCH rdata: expected %h, actual %h", exp_front[65:34], rsp_rdata_o);
            error_count = error_count + 1;
        end

    assert property (@(posedge clock) disable iff (reset)
            rsp_valid_o |-> ({rsp_illegal_o, rsp_redirect_o} == exp_front[33:32]))
        else begin
            $error("MISMATCH illegal/redirect: expected %b, actual %b",
                   exp_front[33:32], {rsp_illegal_o, rsp_redirect_o});
            error_count = error_count + 1;
        end

    assert property (@(posedge clock) disable iff (reset)
            rsp_valid_o |-> (rsp_target_o == exp_front[31:0]))
        else begin
            $error("MISMATCH target: expected %h, actual %h", exp_front[31:0], rsp_target_o);
            error_count = error_count + 1;
        end

    assert property (@(posedge clock) disable iff (reset)
            rsp_count <= RSP_CREDITS + rsp_credit_count)
        else begin
            $error("more responses than response credits");
            error_count = error_count + 1;
        end

    assert property (@(posedge clock) disable iff (reset) req_credit_count <= accept_count)
        else begin
            $error("more request credits returned than requests accepted");
            error_count = error_count + 1;
        end

endmodule

bind csr_unit_top csr_unit_properties #(
    .RSP_CREDITS (RSP_CREDITS)
) props (
    .clock          (clock),
    .reset          (reset),
    .req_valid_i    (req_valid_i),
    .req_op_i       (req_op_i),
    .req_addr_i     (req_addr_i),
    .req_src_i      (req_src_i),
    .req_pc_i       (req_pc_i),
    .req_credit_o   (req_credit_o),
    .rsp_credit_i   (rsp_credit_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_rdata_o    (rsp_rdata_o),
    .rsp_illegal_o  (rsp_illegal_o),
    .rsp_redirect_o (rsp_redirect_o),
    .rsp_target_o   (rsp_target_o)
);

// ==== testbench/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb;

    localparam int REQ_DEPTH      = 4;
    localparam int RSP_CREDITS    = 2;
    localparam int TOTAL_REQS     = 92;
    localparam int TIMEOUT_CYCLES = TOTAL_REQS * 8 + 200;

    logic               clock        = 1'b0;
    logic               reset        = 1'b1;
    logic               req_valid_i  = 1'b0;
    logic [2:0]         req_op_i     = '0;
    csr_pkg::csr_addr_t req_addr_i   = '0;
    csr_pkg::xlen_t     req_src_i    = '0;
    csr_pkg::xlen_t     req_pc_i     = '0;
    logic               rsp_credit_i = 1'b0;
    logic               req_credit_o;
    logic               rsp_valid_o;
    csr_pkg::xlen_t     rsp_rdata_o;
    logic               rsp_illegal_o;
    logic               rsp_redirect_o;
    csr_pkg::xlen_t     rsp_target_o;

    logic [15:0]    stim_lfsr = 16'd27838;
    logic [15:0]    rsp_lfsr  = 16'd27838;
    logic [31:0]    delay_bits;
    logic           slow_responder = 1'b0;
    csr_pkg::xlen_t rsp_log [512];
    int sent = 0;
    int returned = 0;
    int rsp_seen = 0;
    int owed = 0;
    int hold = 0;
    int cycles = 0;
    int tb_errors = 0;
    int errors_seen = 0;
    int test_base = 0;

    csr_unit_top #(
        .REQ_DEPTH   (REQ_DEPTH),
        .RSP_CREDITS (RSP_CREDITS)
    ) dut (.*);

    always #2 clock = ~clock;

    // fibonacci lfsr, taps 16 14 13 11.
    task automatic take_bits(input int n, inout logic [15:0] state, output logic [31:0] value);
        logic fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = state[15] ^ state[13] ^ state[12] ^ state[10];
            state = {state[14:0], fb};
            value = {value[30:0], fb};
        end
    endtask

    function automatic csr_pkg::csr_addr_t pick_addr(input logic [2:0] sel);
        case (sel)
            3'd0:    return csr_pkg::ADDR_MSTATUS;
            3'd1:    return csr_pkg::ADDR_MTVEC;
            3'd2:    return csr_pkg::ADDR_MEPC;
            3'd3:    return csr_pkg::ADDR_MCAUSE;
            3'd4:    return csr_pkg::ADDR_MVENDORID;
            3'd5:    return csr_pkg::ADDR_MARCHID;
            default: return 12'h7C5;  // unmapped.
        endcase
    endfunction

    task automatic send_req(input logic [2:0] op, input csr_pkg::csr_addr_t addr,
                            input csr_pkg::xlen_t src, input csr_pkg::xlen_t pc);
        @(posedge clock);
        while (REQ_DEPTH + returned - sent <= 0) begin
            req_valid_i <= 1'b0;  // out of credits.
            @(posedge clock);
        end
        req_valid_i <= 1'b1;
        req_op_i    <= op;
        req_addr_i  <= addr;
        req_src_i   <= src;
        req_pc_i    <= pc;
        sent = sent + 1;
    endtask

    task automatic drain();
        @(posedge clock);
        req_valid_i <= 1'b0;
        while (rsp_seen != sent) begin
            @(posedge clock);
        end
    endtask

    task automatic check_rsp(input string name, input int idx, input csr_pkg::xlen_t expected);
        if (rsp_log[idx] !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, rsp_log[idx]);
            tb_errors = tb_errors + 1;
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = tb_errors + dut.props.error_count - errors_seen;
        $display("test %-12s %3d requests, %0d errors", name, sent - test_base, errs);
        errors_seen = errors_seen + errs;
        test_base   = sent;
    endtask

    always @(posedge clock) begin
        returned <= reset ? 0 : returned + int'(req_credit_o);
        if (!reset && rsp_valid_o) begin
            rsp_log[rsp_seen] <= rsp_rdata_o;
            rsp_seen          <= rsp_seen + 1;
        end
    end

    // responder, credits back after a random hold.
    always @(posedge clock) begin
        if (reset) begin
            owed         <= 0;
            hold         <= 0;
            rsp_credit_i <= 1'b0;
        end else if (owed != 0 && hold == 0) begin
            take_bits(slow_responder ? 4 : 2, rsp_lfsr, delay_bits);
            rsp_credit_i <= 1'b1;
            owed         <= owed + int'(rsp_valid_o) - 1;
            hold         <= int'(delay_bits);
        end else begin
            rsp_credit_i <= 1'b0;
            owed         <= owed + int'(rsp_valid_o);
            if (hold != 0) hold <= hold - 1;
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        logic [31:0]        r;
        logic [2:0]         op;
        csr_pkg::csr_addr_t addr;
        csr_pkg::xlen_t     src;
        csr_pkg::xlen_t     pc;
        int                 base;
        repeat (4) begin
            @(negedge clock);
            if (rsp_valid_o !== 1'b0 || req_credit_o !== 1'b0) begin
                $display("reset_state: response or credit output active during reset");
                tb_errors = tb_errors + 1;
            end
        end
        @(posedge clock);
        reset <= 1'b0;

        base = sent;
        for (int i = 0; i < 6; i++) send_req(csr_pkg::OP_RS, pick_addr(3'(i)), '0, '0);
        drain();
        for (int i = 0; i < 4; i++) check_rsp("reset_state", base + i, '0);
        check_rsp("reset_state", base + 4, csr_pkg::MVENDORID_RESET);
        check_rsp("reset_state", base + 5, csr_pkg::MARCHID_RESET);
        end_test("reset_state");

        for (int i = 0; i < 20; i++) begin
            take_bits(2, stim_lfsr, r);
            op = (r[1:0] == 2'd0) ? csr_pkg::OP_RW :
                 (r[1:0] == 2'd1) ? csr_pkg::OP_RS : csr_pkg::OP_RC;
            take_bits(2, stim_lfsr, r);
            addr = pick_addr({1'b0, r[1:0]});
            take_bits(3, stim_lfsr, r);
            src = '0;
            if (r[2:0] != 3'd0) take_bits(32, stim_lfsr, src);
            send_req(op, addr, src, '0);
            send_req(csr_pkg::OP_RS, addr, '0, '0);  // read back, same address.
        end
        drain();
        end_test("rmw");

        for (int i = 0; i < 4; i++) begin
            take_bits(6, stim_lfsr, r);
            addr = 12'h7C0 | {6'd0, r[5:0]};
            take_bits(32, stim_lfsr, src);
            send_req(3'(i % 3), addr, src, '0);
        end
        send_req(csr_pkg::OP_RW, csr_pkg::ADDR_MVENDORID, src, '0);
        send_req(csr_pkg::OP_RW, csr_pkg::ADDR_MARCHID, ~src, '0);
        send_req(csr_pkg::OP_RS, csr_pkg::ADDR_MVENDORID, src | 32'h1, '0);
        send_req(csr_pkg::OP_RS, csr_pkg::ADDR_MARCHID, 32'h8000_0000, '0);
        send_req(csr_pkg::OP_RC, csr_pkg::ADDR_MVENDORID, 32'hFFFF_FFFF, '0);
        base = sent;
        send_req(csr_pkg::OP_RS, csr_pkg::ADDR_MVENDORID, '0, '0);
        send_req(csr_pkg::OP_RS, csr_pkg::ADDR_MARCHID, '0, '0);
        drain();
        check_rsp("illegal", base, csr_pkg::MVENDORID_RESET);
        check_rsp("illegal", base + 1, csr_pkg::MARCHID_RESET);
        end_test("illegal");

        take_bits(32, stim_lfsr, r);
        send_req(csr_pkg::OP_RW, csr_pkg::ADDR_MTVEC, r & ~32'h3, '0);
        take_bits(32, stim_lfsr, pc);
        pc   = pc & ~32'h3;
        base = sent;
        send_req(csr_pkg::OP_ECALL, '0, '0, pc);
        send_req(csr_pkg::OP_RS, csr_pkg::ADDR_MEPC, '0, '0);
        send_req(csr_pkg::OP_RS, csr_pkg::ADDR_MCAUSE, '0, '0);
        send_req(csr_pkg::OP_MRET, '0, '0, '0);
        drain();
        check_rsp("traps", base + 1, pc);
        check_rsp("traps", base + 2, 32'd11);
        end_test("traps");

        slow_responder <= 1'b1;
        for (int i = 0; i < 30; i++) begin
            take_bits(3, stim_lfsr, r);
            op = (r[2:0] > 3'd4) ? csr_pkg::OP_RS : r[2:0];
            take_bits(3, stim_lfsr, r);
            addr = pick_addr(r[2:0]);
            take_bits(32, stim_lfsr, src);
            take_bits(32, stim_lfsr, pc);
            send_req(op, addr, src, pc & ~32'h3);
        end
        drain();
        slow_responder <= 1'b0;
        end_test("flow");

        $display("summary: %0d requests, %0d testbench errors, %0d assertion errors",
                 sent, tb_errors, dut.props.error_count);
        if (tb_errors == 0 && dut.props.error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== project.f ====
common/csr_pkg.sv
common/csr_if.sv
hw/credit_rx_fifo.sv
csr/csr_file.sv
csr/csr_exec.sv
hw/csr_unit_top.sv
testbench/csr_unit_properties.sv
testbench/csr_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module csr_unit_tb -o csr_unit_sim

out=$(./obj_dir/csr_unit_sim +verilator+error+limit+1000)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi
